// File: all.f
+incdir+source
source/rs_alu_pkg.sv
source/source_manager.sv
source/rs_alu_entry.sv
source/rs_alloc.sv
source/rs_issue_select.sv
source/rs_alu.sv
sim/rs_alu_sva.sv
sim/rs_alu_tb.sv

// File: sim/rs_alu_sva.sv
`include "rs_alu_cfg.svh"

module rs_alu_sva (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   dispatch_we_i,
    input logic                   full_i,
    input logic [`RS_ENTRIES-1:0] free_i,
    input logic [`RS_ENTRIES-1:0] busy_i
);

    // dispatch has to hold off while every entry is taken
    no_dispatch_when_full: assert property (
        @(posedge clk_i) disable iff (reset_i) full_i |-> !dispatch_we_i
    ) else $error("dispatch strobe while the station is full");

    free_onehot: assert property (
        @(posedge clk_i) disable iff (reset_i) $onehot0(free_i)
    ) else $error("free pulse is not one-hot");

    free_clears_busy: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (|free_i) |=> ((busy_i & $past(free_i)) == '0)
    ) else $error("freed entry still busy in the next cycle");

endmodule

bind rs_alu rs_alu_sva u_sva (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .dispatch_we_i (dispatch_we_i),
    .full_i        (full_o),
    .free_i        (free),
    .busy_i        (busy)
);

// File: sim/rs_alu_tb.sv
`include "rs_alu_cfg.svh"

module rs_alu_tb;

    import rs_alu_pkg::*;

    typedef logic [`RS_RRF_SEL-1:0] tag_t;
    typedef logic [`RS_DATA_LEN-1:0] data_t;

    localparam int TAG_NUM = 1 << `RS_RRF_SEL;
    localparam int WAIT_LIMIT = 200;

    logic         clk_i;
    logic         reset_i;
    logic         dispatch_we_i;
    rs_dispatch_t dispatch_i;
    fwd_array_t   fwd_i;
    logic         full_o;
    rs_issue_t    issue_o;

    // scoreboard indexed by rrf_tag
    rs_issue_t expected [TAG_NUM];
    logic      in_flight [TAG_NUM];
    tag_t      next_tag;
    int        sent_cnt;
    int        issued_cnt;

    rs_alu dut_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .dispatch_we_i (dispatch_we_i),
        .dispatch_i    (dispatch_i),
        .fwd_i         (fwd_i),
        .full_o        (full_o),
        .issue_o       (issue_o)
    );

    always #2 clk_i = ~clk_i;

    // result of any tag is known up front
    function automatic data_t fwd_value(input tag_t tag);
        return (32'h9e37_79b9 * (`RS_DATA_LEN'(tag) + 1)) ^ 32'h0f0f_5a5a;
    endfunction

    function automatic data_t ref_operand(input data_t op, input logic valid);
        if (valid) begin
            return op;
        end else begin
            return fwd_value(op[`RS_RRF_SEL-1:0]);
        end
    endfunction

    function automatic rs_issue_t expect_issue(input rs_dispatch_t d);
        rs_issue_t e;
        e.valid = 1'b1;
        e.pc = d.pc;
        e.op_1 = ref_operand(d.op_1, d.op_1_valid);
        e.op_2 = ref_operand(d.op_2, d.op_2_valid);
        e.imm = d.imm;
        e.rrf_tag = d.rrf_tag;
        e.dst_val = d.dst_val;
        e.alu_op = d.alu_op;
        e.src_a = d.src_a;
        e.src_b = d.src_b;
        return e;
    endfunction

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input data_t got, input data_t exp);
        $display("[ERROR] %s: expected %h, got %h", name, exp, got);
        stop_run();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_value(name, data_t'(got), data_t'(exp));
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            report_value(name, data_t'(got), data_t'(exp));
        end
    endtask

    task automatic check_issue(input rs_issue_t got, input rs_issue_t exp);
        if (got.valid !== exp.valid) begin
            report_value("issue_o.valid", data_t'(got.valid), data_t'(exp.valid));
        end else if (got.pc !== exp.pc) begin
            report_value("issue_o.pc", data_t'(got.pc), data_t'(exp.pc));
        end else if (got.op_1 !== exp.op_1) begin
            report_value("issue_o.op_1", got.op_1, exp.op_1);
        end else if (got.op_2 !== exp.op_2) begin
            report_value("issue_o.op_2", got.op_2, exp.op_2);
        end else if (got.imm !== exp.imm) begin
            report_value("issue_o.imm", got.imm, exp.imm);
        end else if (got.dst_val !== exp.dst_val) begin
            report_value("issue_o.dst_val", data_t'(got.dst_val), data_t'(exp.dst_val));
        end else if (got.alu_op !== exp.alu_op) begin
            report_value("issue_o.alu_op", data_t'(got.alu_op), data_t'(exp.alu_op));
        end else if (got.src_a !== exp.src_a) begin
            report_value("issue_o.src_a", data_t'(got.src_a), data_t'(exp.src_a));
        end else if (got.src_b !== exp.src_b) begin
            report_value("issue_o.src_b", data_t'(got.src_b), data_t'(exp.src_b));
        end
    endtask

    // issue_o is stable at the falling edge
    always @(negedge clk_i) begin
        if (!reset_i && issue_o.valid) begin
            if (!in_flight[issue_o.rrf_tag]) begin
                $display("issue for rrf_tag %0d, which is not in flight", issue_o.rrf_tag);
                stop_run();
            end else begin
                check_issue(issue_o, expected[issue_o.rrf_tag]);
                in_flight[issue_o.rrf_tag] = 1'b0;
                issued_cnt++;
            end
        end
    end

    // strobe and buses drop back to idle on each falling edge
    task automatic cycle();
        @(negedge clk_i);
        dispatch_we_i = 1'b0;
        fwd_i = '0;
    endtask

    task automatic set_bus(input int idx, input tag_t tag);
        fwd_i[idx].valid = 1'b1;
        fwd_i[idx].dst = tag;
        fwd_i[idx].result = fwd_value(tag);
    endtask

    task automatic build_inst(input logic p1, input tag_t t1, input logic p2, input tag_t t2,
                              output rs_dispatch_t d);
        d.pc = $urandom();
        d.op_1 = $urandom();
        d.op_2 = $urandom();
        if (p1) begin
            d.op_1[`RS_RRF_SEL-1:0] = t1;
        end
        if (p2) begin
            d.op_2[`RS_RRF_SEL-1:0] = t2;
        end
        d.op_1_valid = !p1;
        d.op_2_valid = !p2;
        d.imm = $urandom();
        // skip tags still waiting in the station
        while (in_flight[next_tag]) begin
            next_tag = next_tag + 1'b1;
        end
        d.rrf_tag = next_tag;
        next_tag = next_tag + 1'b1;
        d.dst_val = 1'($urandom_range(0, 1));
        d.alu_op = alu_op_e'($urandom_range(0, 9));
        d.src_a = src_a_sel_e'($urandom_range(0, 2));
        d.src_b = src_b_sel_e'($urandom_range(0, 2));
    endtask

    task automatic send_inst(input rs_dispatch_t d);
        expected[d.rrf_tag] = expect_issue(d);
        in_flight[d.rrf_tag] = 1'b1;
        sent_cnt++;
        dispatch_i = d;
        dispatch_we_i = 1'b1;
    endtask

    task automatic wait_issue(input tag_t tag);
        int waited;
        waited = 0;
        while (!(issue_o.valid && issue_o.rrf_tag == tag)) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for rrf_tag %0d to issue", tag);
                stop_run();
            end else begin
                waited++;
                cycle();
            end
        end
    endtask

    // sweep every tag over the buses until nothing is left in flight
    task automatic drain_all();
        int waited;
        int base;
        waited = 0;
        base = 0;
        while (sent_cnt != issued_cnt) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for the station to drain");
                stop_run();
            end else begin
                for (int i = 0; i < `RS_FWD_NUM; i++) begin
                    set_bus(i, tag_t'((base + i) % TAG_NUM));
                end
                base = (base + `RS_FWD_NUM) % TAG_NUM;
                waited++;
                cycle();
            end
        end
    endtask

    task automatic random_step();
        rs_dispatch_t d;
        logic p1;
        logic p2;
        tag_t t1;
        tag_t t2;
        for (int i = 0; i < `RS_FWD_NUM; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                set_bus(i, tag_t'($urandom_range(0, 15)));
            end
        end
        if (!full_o && $urandom_range(0, 3) != 0) begin
            p1 = 1'($urandom_range(0, 1));
            p2 = 1'($urandom_range(0, 1));
            t1 = tag_t'($urandom_range(0, 15));
            t2 = tag_t'($urandom_range(0, 15));
            build_inst(p1, t1, p2, t2, d);
            // sometimes the result shows up in the dispatch cycle itself
            if (p1 && $urandom_range(0, 3) == 0) begin
                set_bus(0, t1);
            end
            send_inst(d);
        end
        cycle();
    endtask

    task automatic expect_issue_in_two(input tag_t tag);
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b0);
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b1);
        check_tag("issue_o.rrf_tag", issue_o.rrf_tag, tag);
    endtask

    initial begin
        rs_dispatch_t d_a;
        rs_dispatch_t d_b;
        rs_dispatch_t d_f;
        void'($urandom(10));
        clk_i = 1'b0;
        reset_i = 1'b1;
        dispatch_we_i = 1'b0;
        dispatch_i = '0;
        fwd_i = '0;
        next_tag = '0;
        sent_cnt = 0;
        issued_cnt = 0;
        for (int i = 0; i < TAG_NUM; i++) begin
            in_flight[i] = 1'b0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        check_flag("issue_o.valid", issue_o.valid, 1'b0);
        check_flag("full_o", full_o, 1'b0);

        // both operands ready so it issues two cycles on
        build_inst(1'b0, '0, 1'b0, '0, d_a);
        send_inst(d_a);
        expect_issue_in_two(d_a.rrf_tag);
        cycle();

        // results broadcast in the dispatch cycle
        build_inst(1'b1, tag_t'(40), 1'b1, tag_t'(41), d_a);
        send_inst(d_a);
        set_bus(2, tag_t'(40));
        set_bus(4, tag_t'(41));
        expect_issue_in_two(d_a.rrf_tag);
        cycle();

        // result broadcast later
        build_inst(1'b1, tag_t'(42), 1'b0, '0, d_a);
        send_inst(d_a);
        cycle();
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b0);
        set_bus(1, tag_t'(42));
        expect_issue_in_two(d_a.rrf_tag);
        drain_all();

        repeat (400) random_step();
        drain_all();

        // fill up on tags nobody broadcasts
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            check_flag("full_o", full_o, 1'b0);
            build_inst(1'b1, tag_t'(16 + i), 1'b0, '0, d_a);
            if (i == 3) begin
                d_f = d_a;
            end
            send_inst(d_a);
            cycle();
        end
        check_flag("full_o", full_o, 1'b1);
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b0);
        check_flag("full_o", full_o, 1'b1);
        set_bus(0, tag_t'(19));
        cycle();
        wait_issue(d_f.rrf_tag);
        check_flag("full_o", full_o, 1'b0);
        drain_all();

        // younger instruction in entry 0, older one in entry 1
        build_inst(1'b1, tag_t'(51), 1'b0, '0, d_f);
        send_inst(d_f);
        cycle();
        build_inst(1'b1, tag_t'(50), 1'b0, '0, d_a);
        send_inst(d_a);
        cycle();
        set_bus(0, tag_t'(51));
        cycle();
        wait_issue(d_f.rrf_tag);
        build_inst(1'b1, tag_t'(50), 1'b0, '0, d_b);
        send_inst(d_b);
        cycle();
        set_bus(3, tag_t'(50));
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b0);
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b1);
        check_tag("issue_o.rrf_tag", issue_o.rrf_tag, d_b.rrf_tag);
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b1);
        check_tag("issue_o.rrf_tag", issue_o.rrf_tag, d_a.rrf_tag);
        cycle();
        check_flag("issue_o.valid", issue_o.valid, 1'b0);
        drain_all();
        cycle();

        if (issued_cnt == sent_cnt) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("%0d issues for %0d dispatches", issued_cnt, sent_cnt);
            stop_run();
        end
    end

endmodule

// File: source/rs_alloc.sv
`include "rs_alu_cfg.svh"

module rs_alloc (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   dispatch_we_i,
    input  logic [`RS_ENTRIES-1:0] free_i,
    output logic [`RS_ENTRIES-1:0] entry_we_o,
    output logic [`RS_ENTRIES-1:0] busy_o,
    output logic                   full_o
);

    logic [`RS_ENTRIES-1:0] busy_q;
    logic [`RS_ENTRIES-1:0] first_free;

    // lowest clear bit of busy, zero when every entry is taken
    assign first_free = ~busy_q & (busy_q + 1'b1);

    // a strobe while full finds no free entry and is dropped
    assign entry_we_o = dispatch_we_i ? first_free : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q | entry_we_o) & ~free_i;
        end
    end

    assign busy_o = busy_q;
    assign full_o = &busy_q;

endmodule

// File: source/rs_alu.sv
`include "rs_alu_cfg.svh"

module rs_alu (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     dispatch_we_i,
    input  rs_alu_pkg::rs_dispatch_t dispatch_i,
    input  rs_alu_pkg::fwd_array_t   fwd_i,
    output logic                     full_o,
    output rs_alu_pkg::rs_issue_t    issue_o
);

    import rs_alu_pkg::*;

    logic [`RS_ENTRIES-1:0] entry_we;
    logic [`RS_ENTRIES-1:0] busy;
    logic [`RS_ENTRIES-1:0] ready;
    logic [`RS_ENTRIES-1:0] free;

    rs_issue_t [`RS_ENTRIES-1:0] entries;

    rs_alloc u_alloc (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .dispatch_we_i (dispatch_we_i),
        .free_i        (free),
        .entry_we_o    (entry_we),
        .busy_o        (busy),
        .full_o        (full_o)
    );

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_entry
        rs_alu_entry u_entry (
            .clk_i      (clk_i),
            .reset_i    (reset_i),
            .busy_i     (busy[i]),
            .we_i       (entry_we[i]),
            .dispatch_i (dispatch_i),
            .fwd_i      (fwd_i),
            .ready_o    (ready[i]),
            .entry_o    (entries[i])
        );
    end

    // freed entry drops busy on the same edge the packet is issued
    rs_issue_select u_select (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .ready_i   (ready),
        .entries_i (entries),
        .free_o    (free),
        .issue_o   (issue_o)
    );

endmodule

// File: source/rs_alu_cfg.svh
`ifndef RS_ALU_CFG_SVH
`define RS_ALU_CFG_SVH

// operand and pc widths
`define RS_DATA_LEN 32
`define RS_ADDR_LEN 32

// renamed register tag width
`define RS_RRF_SEL 6

// station depth, RS_ENTRY_SEL must cover RS_ENTRIES
`define RS_ENTRIES 8
`define RS_ENTRY_SEL 3

// result buses watched by every entry
`define RS_FWD_NUM 5

`endif

// File: source/rs_alu_entry.sv
`include "rs_alu_cfg.svh"

module rs_alu_entry (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     busy_i,
    input  logic                     we_i,
    input  rs_alu_pkg::rs_dispatch_t dispatch_i,
    input  rs_alu_pkg::fwd_array_t   fwd_i,
    output logic                     ready_o,
    output rs_alu_pkg::rs_issue_t    entry_o
);

    import rs_alu_pkg::*;

    rs_dispatch_t inst_q;

    logic [`RS_DATA_LEN-1:0] op_1_q;
    logic [`RS_DATA_LEN-1:0] op_2_q;
    logic                    op_1_valid_q;
    logic                    op_2_valid_q;

    logic [`RS_DATA_LEN-1:0] op_1_src;
    logic [`RS_DATA_LEN-1:0] op_2_src;
    logic                    op_1_src_valid;
    logic                    op_2_src_valid;

    logic [`RS_DATA_LEN-1:0] op_1_next;
    logic [`RS_DATA_LEN-1:0] op_2_next;
    logic                    op_1_resolved;
    logic                    op_2_resolved;

    // a write feeds the incoming operands through the resolvers,
    // so a broadcast in the dispatch cycle is caught
    assign op_1_src = we_i ? dispatch_i.op_1 : op_1_q;
    assign op_2_src = we_i ? dispatch_i.op_2 : op_2_q;
    assign op_1_src_valid = we_i ? dispatch_i.op_1_valid : op_1_valid_q;
    assign op_2_src_valid = we_i ? dispatch_i.op_2_valid : op_2_valid_q;

    source_manager u_src_1 (
        .src_i       (op_1_src),
        .src_ready_i (op_1_src_valid),
        .fwd_i       (fwd_i),
        .src_o       (op_1_next),
        .resolved_o  (op_1_resolved)
    );

    source_manager u_src_2 (
        .src_i       (op_2_src),
        .src_ready_i (op_2_src_valid),
        .fwd_i       (fwd_i),
        .src_o       (op_2_next),
        .resolved_o  (op_2_resolved)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            op_1_valid_q <= 1'b0;
            op_2_valid_q <= 1'b0;
        end else begin
            op_1_valid_q <= op_1_resolved;
            op_2_valid_q <= op_2_resolved;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            inst_q <= dispatch_i;
        end
        op_1_q <= op_1_next;
        op_2_q <= op_2_next;
    end

    assign ready_o = busy_i & op_1_valid_q & op_2_valid_q;

    always_comb begin
        entry_o.valid = ready_o;
        entry_o.pc = inst_q.pc;
        entry_o.op_1 = op_1_q;
        entry_o.op_2 = op_2_q;
        entry_o.imm = inst_q.imm;
        entry_o.rrf_tag = inst_q.rrf_tag;
        entry_o.dst_val = inst_q.dst_val;
        entry_o.alu_op = inst_q.alu_op;
        entry_o.src_a = inst_q.src_a;
        entry_o.src_b = inst_q.src_b;
    end

endmodule

// File: source/rs_alu_pkg.sv
`include "rs_alu_cfg.svh"

package rs_alu_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // first alu input
    typedef enum logic [1:0] {
        src_a_op_1 = 2'd0,
        src_a_pc   = 2'd1,
        src_a_zero = 2'd2
    } src_a_sel_e;

    // second alu input
    typedef enum logic [1:0] {
        src_b_op_2 = 2'd0,
        src_b_imm  = 2'd1,
        src_b_four = 2'd2
    } src_b_sel_e;

    // pending operands carry their tag in the low bits
    typedef struct packed {
        logic [`RS_ADDR_LEN-1:0] pc;
        logic [`RS_DATA_LEN-1:0] op_1;
        logic [`RS_DATA_LEN-1:0] op_2;
        logic                    op_1_valid;
        logic                    op_2_valid;
        logic [`RS_DATA_LEN-1:0] imm;
        logic [`RS_RRF_SEL-1:0]  rrf_tag;
        logic                    dst_val;
        alu_op_e                 alu_op;
        src_a_sel_e              src_a;
        src_b_sel_e              src_b;
    } rs_dispatch_t;

    typedef struct packed {
        logic                    valid;
        logic [`RS_RRF_SEL-1:0]  dst;
        logic [`RS_DATA_LEN-1:0] result;
    } fwd_bus_t;

    typedef fwd_bus_t [`RS_FWD_NUM-1:0] fwd_array_t;

    typedef struct packed {
        logic                    valid;
        logic [`RS_ADDR_LEN-1:0] pc;
        logic [`RS_DATA_LEN-1:0] op_1;
        logic [`RS_DATA_LEN-1:0] op_2;
        logic [`RS_DATA_LEN-1:0] imm;
        logic [`RS_RRF_SEL-1:0]  rrf_tag;
        logic                    dst_val;
        alu_op_e                 alu_op;
        src_a_sel_e              src_a;
        src_b_sel_e              src_b;
    } rs_issue_t;

endpackage

// File: source/rs_issue_select.sv
`include "rs_alu_cfg.svh"

module rs_issue_select (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic [`RS_ENTRIES-1:0]                   ready_i,
    input  rs_alu_pkg::rs_issue_t [`RS_ENTRIES-1:0]  entries_i,
    output logic [`RS_ENTRIES-1:0]                   free_o,
    output rs_alu_pkg::rs_issue_t                    issue_o
);

    import rs_alu_pkg::*;

    rs_issue_t               issue_q;
    logic                    issue_valid_q;
    logic [`RS_ENTRY_SEL-1:0] sel_idx;
    logic                    any_ready;

    assign any_ready = |ready_i;

    // one-hot of the lowest ready entry
    assign free_o = ready_i & (~ready_i + 1'b1);

    always_comb begin
        sel_idx = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (ready_i[i]) begin
                sel_idx = i[`RS_ENTRY_SEL-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= any_ready;
        end
    end

    always_ff @(posedge clk_i) begin
        if (any_ready) begin
            issue_q <= entries_i[sel_idx];
        end
    end

    always_comb begin
        issue_o = issue_q;
        issue_o.valid = issue_valid_q;
    end

endmodule

// File: source/source_manager.sv
`include "rs_alu_cfg.svh"

module source_manager (
    input  logic [`RS_DATA_LEN-1:0] src_i,
    input  logic                    src_ready_i,
    input  rs_alu_pkg::fwd_array_t  fwd_i,
    output logic [`RS_DATA_LEN-1:0] src_o,
    output logic                    resolved_o
);

    logic [`RS_RRF_SEL-1:0] wait_tag;

    assign wait_tag = src_i[`RS_RRF_SEL-1:0];

    // walk from the top bus down so the lowest matching bus wins
    always_comb begin
        src_o = src_i;
        resolved_o = src_ready_i;
        if (!src_ready_i) begin
            for (int i = `RS_FWD_NUM - 1; i >= 0; i--) begin
                if (fwd_i[i].valid && (fwd_i[i].dst == wait_tag)) begin
                    src_o = fwd_i[i].result;
                    resolved_o = 1'b1;
                end
            end
        end
    end

endmodule
